/* logic/periph_bus_pkg.sv */
/*
 * Peripheral bus widths, address map and request encodings.
 * Imported by the decode stage, the execute units and the result stage.
 */
`default_nettype none

package periph_bus_pkg;

   // Bus widths
   localparam int unsigned ADDR_W = 12;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned ID_W   = 5;

   // ******************************
   // Address map
   // ******************************
   localparam int unsigned ADDR_UNIT_MSB = 11;
   localparam int unsigned ADDR_UNIT_LSB = 8;
   localparam int unsigned ADDR_REG_MSB  = 4;
   localparam int unsigned ADDR_REG_LSB  = 2;
   localparam int unsigned REG_IDX_W     = ADDR_REG_MSB - ADDR_REG_LSB + 1;

   // Unit field values, anything else is unmapped
   localparam logic [3:0] UNIT_FIELD_CTRL  = 4'h0;
   localparam logic [3:0] UNIT_FIELD_TIMER = 4'h1;
   localparam logic [3:0] UNIT_FIELD_EVENT = 4'h2;

   // Read data for unmapped addresses
   localparam logic [DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

   // Bus wen high means read
   typedef enum logic {
      OP_WRITE = 1'b0,
      OP_READ  = 1'b1
   } op_e;

   typedef enum logic [1:0] {
      UNIT_CTRL  = 2'd0,
      UNIT_TIMER = 2'd1,
      UNIT_EVENT = 2'd2,
      UNIT_NONE  = 2'd3
   } unit_e;

endpackage

`default_nettype wire

/* logic/cluster_ctrl_pkg.sv */
/*
 * Cluster sizes, event widths and register indices of the execute units.
 */
`default_nettype none

package cluster_ctrl_pkg;

   // Cluster size
   localparam int unsigned NB_CORES      = 4;
   localparam int unsigned RETURN_W      = 2;

   // Event buffer layout, timer event sits above the external ones
   localparam int unsigned NB_EXT_EVENTS = 8;
   localparam int unsigned NB_EVENTS     = NB_EXT_EVENTS + 1;
   localparam int unsigned TIMER_EVT_BIT = NB_EXT_EVENTS;

   // ******************************
   // Register indices
   // ******************************
   // Cluster control unit
   localparam logic [2:0] CTRL_REG_EOC      = 3'd0;
   localparam logic [2:0] CTRL_REG_FETCH_EN = 3'd1;
   localparam logic [2:0] CTRL_REG_RETURN   = 3'd2;

   // Timer unit
   localparam logic [2:0] TMR_REG_CTRL      = 3'd0;
   localparam logic [2:0] TMR_REG_COUNT     = 3'd1;
   localparam logic [2:0] TMR_REG_COMPARE   = 3'd2;

   // Event unit, masks at 0 up to NB_CORES-1
   localparam logic [2:0] EVT_REG_MASK_BASE = 3'd0;
   localparam logic [2:0] EVT_REG_BUFFER    = 3'd4;
   localparam logic [2:0] EVT_REG_CLEAR     = 3'd5;

endpackage

`default_nettype wire

/* logic/periph_req_if.sv */
/*
 * Decoded peripheral request, driven by the decode stage and
 * seen by the execute units and the result stage.
 */
`timescale 1ns/1ps
`default_nettype none

interface periph_req_if;

   import periph_bus_pkg::*;

   // One-cycle strobe per request
   logic                 valid;
   // Target unit, UNIT_NONE when unmapped
   unit_e                unit_sel;
   op_e                  op;
   logic [REG_IDX_W-1:0] reg_idx;
   logic [DATA_W-1:0]    wdata;
   logic [ID_W-1:0]      id;

   modport master (
      output valid, unit_sel, op, reg_idx, wdata, id
   );

   // Execute units act only on their own unit_sel
   modport unit (
      input valid, unit_sel, op, reg_idx, wdata
   );

   modport result (
      input valid, unit_sel, op, id
   );

endinterface

`default_nettype wire

/* logic/periph_decode.sv */
/*
 * Decode stage of the peripheral bus. Registers every request and
 * steers it to an execute unit by the unit field of the address.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_decode (
   input  wire logic                             clk_i,
   input  wire logic                             rst_ni,
   input  wire logic                             req_i,
   input  wire logic [periph_bus_pkg::ADDR_W-1:0] add_i,
   input  wire logic                             wen_i,
   input  wire logic [periph_bus_pkg::DATA_W-1:0] wdata_i,
   input  wire logic [periph_bus_pkg::ID_W-1:0]   id_i,
   periph_req_if.master                          req_o
);

   import periph_bus_pkg::*;

   unit_e unit_d;
   op_e   op_d;

   // Unit field lookup
   always_comb begin
      case (add_i[ADDR_UNIT_MSB:ADDR_UNIT_LSB])
         UNIT_FIELD_CTRL:  unit_d = UNIT_CTRL;
         UNIT_FIELD_TIMER: unit_d = UNIT_TIMER;
         UNIT_FIELD_EVENT: unit_d = UNIT_EVENT;
         default:          unit_d = UNIT_NONE;
      endcase
   end

   assign op_d = wen_i ? OP_READ : OP_WRITE;

   // One request strobe per cycle
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         req_o.valid <= 1'b0;
      end else begin
         req_o.valid <= req_i;
      end
   end

   // Payload loads only with a request
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         req_o.unit_sel <= UNIT_CTRL;
         req_o.op       <= OP_WRITE;
         req_o.reg_idx  <= '0;
         req_o.wdata    <= '0;
         req_o.id       <= '0;
      end else if (req_i) begin
         req_o.unit_sel <= unit_d;
         req_o.op       <= op_d;
         req_o.reg_idx  <= add_i[ADDR_REG_MSB:ADDR_REG_LSB];
         req_o.wdata    <= wdata_i;
         req_o.id       <= id_i;
      end
   end

   // Valid may only rise once reset was already released
   a_no_valid_in_reset: assert property (
      @(posedge clk_i) $rose(req_o.valid) |-> $past(rst_ni)
   );

endmodule

`default_nettype wire

/* logic/cluster_ctrl_unit.sv */
/*
 * Cluster control unit. Holds end of computation, the per-core
 * fetch enables and the return code, all reachable from the bus.
 */
`timescale 1ns/1ps
`default_nettype none

module cluster_ctrl_unit (
   input  wire logic                                 clk_i,
   input  wire logic                                 rst_ni,
   periph_req_if.unit                                req_i,
   output logic [periph_bus_pkg::DATA_W-1:0]         rdata_o,
   output logic                                      eoc_o,
   output logic [cluster_ctrl_pkg::NB_CORES-1:0]     fetch_enable_o,
   output logic [cluster_ctrl_pkg::RETURN_W-1:0]     return_o
);

   import periph_bus_pkg::*;
   import cluster_ctrl_pkg::*;

   logic wr_en;

   // Write strobe for this unit
   assign wr_en = req_i.valid && (req_i.unit_sel == UNIT_CTRL) && (req_i.op == OP_WRITE);

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         eoc_o          <= 1'b0;
         fetch_enable_o <= '0;
         return_o       <= '0;
      end else if (wr_en) begin
         case (req_i.reg_idx)
            CTRL_REG_EOC:      eoc_o          <= req_i.wdata[0];
            CTRL_REG_FETCH_EN: fetch_enable_o <= req_i.wdata[NB_CORES-1:0];
            CTRL_REG_RETURN:   return_o       <= req_i.wdata[RETURN_W-1:0];
            default:           ;
         endcase
      end
   end

   // Zero-extended read mux
   always_comb begin
      rdata_o = '0;
      case (req_i.reg_idx)
         CTRL_REG_EOC:      rdata_o[0]            = eoc_o;
         CTRL_REG_FETCH_EN: rdata_o[NB_CORES-1:0] = fetch_enable_o;
         CTRL_REG_RETURN:   rdata_o[RETURN_W-1:0] = return_o;
         // Unknown indices read 0
         default:           rdata_o               = '0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/timer_unit.sv */
/*
 * Timer unit. Free-running counter that restarts on a compare match
 * and pulses an event towards the event unit.
 */
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
   input  wire logic                         clk_i,
   input  wire logic                         rst_ni,
   periph_req_if.unit                        req_i,
   output logic [periph_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                              event_o
);

   import periph_bus_pkg::*;
   import cluster_ctrl_pkg::*;

   logic              enable_q;
   logic [DATA_W-1:0] count_q;
   logic [DATA_W-1:0] compare_q;
   logic              wr_en;
   logic              hit;

   assign wr_en = req_i.valid && (req_i.unit_sel == UNIT_TIMER) && (req_i.op == OP_WRITE);

   // Match, blocked right after a pulse
   assign hit = enable_q && (count_q == compare_q) && !event_o;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         enable_q  <= 1'b0;
         count_q   <= '0;
         compare_q <= '0;
         event_o   <= 1'b0;
      end else begin
         event_o <= hit;
         // Bus write to COUNT overrides counting
         if (wr_en && (req_i.reg_idx == TMR_REG_COUNT)) begin
            count_q <= req_i.wdata;
         end else if (enable_q) begin
            count_q <= hit ? '0 : count_q + 1'b1;
         end
         if (wr_en && (req_i.reg_idx == TMR_REG_CTRL)) begin
            enable_q <= req_i.wdata[0];
         end
         if (wr_en && (req_i.reg_idx == TMR_REG_COMPARE)) begin
            compare_q <= req_i.wdata;
         end
      end
   end

   // Read mux
   always_comb begin
      rdata_o = '0;
      case (req_i.reg_idx)
         TMR_REG_CTRL:    rdata_o[0] = enable_q;
         TMR_REG_COUNT:   rdata_o    = count_q;
         TMR_REG_COMPARE: rdata_o    = compare_q;
         default:         rdata_o    = '0;
      endcase
   end

   a_event_one_cycle: assert property (
      @(posedge clk_i) disable iff (!rst_ni) event_o |=> !event_o
   );

endmodule

`default_nettype wire

/* logic/event_unit.sv */
/*
 * Event unit. Buffers external and timer events and raises one
 * interrupt per core from the buffer and that core's mask.
 */
`timescale 1ns/1ps
`default_nettype none

module event_unit (
   input  wire logic                                   clk_i,
   input  wire logic                                   rst_ni,
   periph_req_if.unit                                  req_i,
   input  wire logic [cluster_ctrl_pkg::NB_EXT_EVENTS-1:0] ext_events_i,
   input  wire logic                                   timer_event_i,
   output logic [periph_bus_pkg::DATA_W-1:0]           rdata_o,
   output logic [cluster_ctrl_pkg::NB_CORES-1:0]       irq_o
);

   import periph_bus_pkg::*;
   import cluster_ctrl_pkg::*;

   logic [NB_EVENTS-1:0]                buffer_q;
   logic [NB_CORES-1:0][NB_EVENTS-1:0]  mask_q;
   logic [NB_EVENTS-1:0]                events_in;
   logic [NB_EVENTS-1:0]                clear_bits;
   logic                                wr_en;

   assign wr_en = req_i.valid && (req_i.unit_sel == UNIT_EVENT) && (req_i.op == OP_WRITE);

   // Incoming events in buffer order
   always_comb begin
      events_in                      = '0;
      events_in[NB_EXT_EVENTS-1:0]   = ext_events_i;
      events_in[TIMER_EVT_BIT]       = timer_event_i;
   end

   // Bits to drop on a CLEAR write
   assign clear_bits = (wr_en && (req_i.reg_idx == EVT_REG_CLEAR)) ?
                       req_i.wdata[NB_EVENTS-1:0] : '0;

   // ******************************
   // Buffer, masks and irq
   // ******************************
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         buffer_q <= '0;
         mask_q   <= '0;
         irq_o    <= '0;
      end else begin
         // New events win over the clear
         buffer_q <= (buffer_q & ~clear_bits) | events_in;
         for (int c = 0; c < NB_CORES; c++) begin
            if (wr_en && (req_i.reg_idx == EVT_REG_MASK_BASE + 3'(c))) begin
               mask_q[c] <= req_i.wdata[NB_EVENTS-1:0];
            end
            // One cycle behind the buffer
            irq_o[c] <= |(buffer_q & mask_q[c]);
         end
      end
   end

   // Read mux, CLEAR reads 0
   always_comb begin
      rdata_o = '0;
      if (req_i.reg_idx == EVT_REG_BUFFER) begin
         rdata_o[NB_EVENTS-1:0] = buffer_q;
      end
      for (int c = 0; c < NB_CORES; c++) begin
         if (req_i.reg_idx == EVT_REG_MASK_BASE + 3'(c)) begin
            rdata_o[NB_EVENTS-1:0] = mask_q[c];
         end
      end
   end

endmodule

`default_nettype wire

/* logic/periph_result.sv */
/*
 * Result stage. Picks the read data of the addressed unit and
 * returns it with the id one cycle after decode.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_result (
   input  wire logic                             clk_i,
   input  wire logic                             rst_ni,
   periph_req_if.result                          req_i,
   input  wire logic [periph_bus_pkg::DATA_W-1:0] ctrl_rdata_i,
   input  wire logic [periph_bus_pkg::DATA_W-1:0] timer_rdata_i,
   input  wire logic [periph_bus_pkg::DATA_W-1:0] event_rdata_i,
   output logic                                  r_valid_o,
   output logic [periph_bus_pkg::DATA_W-1:0]     r_rdata_o,
   output logic                                  r_opc_o,
   output logic [periph_bus_pkg::ID_W-1:0]       r_id_o
);

   import periph_bus_pkg::*;

   logic [DATA_W-1:0] sel_rdata;
   logic              sel_opc;

   // Response select
   always_comb begin
      sel_opc = 1'b0;
      case (req_i.unit_sel)
         UNIT_CTRL:  sel_rdata = ctrl_rdata_i;
         UNIT_TIMER: sel_rdata = timer_rdata_i;
         UNIT_EVENT: sel_rdata = event_rdata_i;
         default: begin
            sel_rdata = ERR_RDATA;
            sel_opc   = 1'b1;
         end
      endcase
      // Mapped writes answer with zero data
      if ((req_i.op == OP_WRITE) && !sel_opc) begin
         sel_rdata = '0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         r_valid_o <= 1'b0;
         r_opc_o   <= 1'b0;
         r_rdata_o <= '0;
         r_id_o    <= '0;
      end else begin
         r_valid_o <= req_i.valid;
         r_opc_o   <= req_i.valid && sel_opc;
         // Data and id hold between responses
         if (req_i.valid) begin
            r_rdata_o <= sel_rdata;
            r_id_o    <= req_i.id;
         end
      end
   end

   a_opc_with_valid: assert property (
      @(posedge clk_i) disable iff (!rst_ni) r_opc_o |-> r_valid_o
   );

endmodule

`default_nettype wire

/* logic/cluster_periph_top.sv */
/*
 * Cluster peripheral block. One shared peripheral bus reaches the
 * control, timer and event units through decode and result stages.
 */
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_top (
   input  wire logic                                   clk_i,
   input  wire logic                                   rst_ni,
   // Peripheral bus request
   input  wire logic                                   req_i,
   input  wire logic [periph_bus_pkg::ADDR_W-1:0]       add_i,
   input  wire logic                                   wen_i,
   input  wire logic [periph_bus_pkg::DATA_W-1:0]       wdata_i,
   input  wire logic [periph_bus_pkg::ID_W-1:0]         id_i,
   input  wire logic [cluster_ctrl_pkg::NB_EXT_EVENTS-1:0] ext_events_i,
   // Peripheral bus response
   output logic                                        r_valid_o,
   output logic [periph_bus_pkg::DATA_W-1:0]           r_rdata_o,
   output logic                                        r_opc_o,
   output logic [periph_bus_pkg::ID_W-1:0]             r_id_o,
   // Cluster control
   output logic                                        eoc_o,
   output logic [cluster_ctrl_pkg::NB_CORES-1:0]       fetch_enable_o,
   output logic [cluster_ctrl_pkg::RETURN_W-1:0]       return_o,
   output logic [cluster_ctrl_pkg::NB_CORES-1:0]       irq_o
);

   import periph_bus_pkg::*;

   logic [DATA_W-1:0] ctrl_rdata;
   logic [DATA_W-1:0] timer_rdata;
   logic [DATA_W-1:0] event_rdata;
   logic              timer_event;

   periph_req_if u_req_if ();

   // ******************************
   // Decode
   // ******************************
   periph_decode u_periph_decode (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (req_i),
      .add_i   (add_i),
      .wen_i   (wen_i),
      .wdata_i (wdata_i),
      .id_i    (id_i),
      .req_o   (u_req_if.master)
   );

   // ******************************
   // Execute units
   // ******************************
   cluster_ctrl_unit u_cluster_ctrl_unit (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_i          (u_req_if.unit),
      .rdata_o        (ctrl_rdata),
      .eoc_o          (eoc_o),
      .fetch_enable_o (fetch_enable_o),
      .return_o       (return_o)
   );

   timer_unit u_timer_unit (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (u_req_if.unit),
      .rdata_o (timer_rdata),
      .event_o (timer_event)
   );

   // Timer event feeds buffer bit 8
   event_unit u_event_unit (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (u_req_if.unit),
      .ext_events_i  (ext_events_i),
      .timer_event_i (timer_event),
      .rdata_o       (event_rdata),
      .irq_o         (irq_o)
   );

   // ******************************
   // Result
   // ******************************
   periph_result u_periph_result (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (u_req_if.result),
      .ctrl_rdata_i  (ctrl_rdata),
      .timer_rdata_i (timer_rdata),
      .event_rdata_i (event_rdata),
      .r_valid_o     (r_valid_o),
      .r_rdata_o     (r_rdata_o),
      .r_opc_o       (r_opc_o),
      .r_id_o        (r_id_o)
   );

endmodule

`default_nettype wire

/* bench/cluster_periph_tb.sv */
/*
 * Testbench for the cluster peripheral block. Bus transactions and
 * expected values come from the stimulus file, one test per line.
 */
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_tb;

   import periph_bus_pkg::*;
   import cluster_ctrl_pkg::*;

   localparam string STIM_FILE   = "bench/cluster_periph_stimulus.txt";
   localparam int    POLL_CYCLES = 20;

   logic                     clk_i;
   logic                     rst_ni;
   logic                     req_i;
   logic [ADDR_W-1:0]        add_i;
   logic                     wen_i;
   logic [DATA_W-1:0]        wdata_i;
   logic [ID_W-1:0]          id_i;
   logic [NB_EXT_EVENTS-1:0] ext_events_i;
   logic                     r_valid_o;
   logic [DATA_W-1:0]        r_rdata_o;
   logic                     r_opc_o;
   logic [ID_W-1:0]          r_id_o;
   logic                     eoc_o;
   logic [NB_CORES-1:0]      fetch_enable_o;
   logic [RETURN_W-1:0]      return_o;
   logic [NB_CORES-1:0]      irq_o;

   // Stimulus table, one entry per file line
   string             names[$];
   string             ops[$];
   string             outs[$];
   logic [DATA_W-1:0] addrs[$];
   logic [DATA_W-1:0] datas[$];
   logic [DATA_W-1:0] exp_vals[$];
   logic [DATA_W-1:0] levels[$];

   string       test_name;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int unsigned cycles      = 0;
   int unsigned cycle_limit = 0;
   bit          limit_set   = 1'b0;

   cluster_periph_top u_cluster_periph_top (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_i          (req_i),
      .add_i          (add_i),
      .wen_i          (wen_i),
      .wdata_i        (wdata_i),
      .id_i           (id_i),
      .ext_events_i   (ext_events_i),
      .r_valid_o      (r_valid_o),
      .r_rdata_o      (r_rdata_o),
      .r_opc_o        (r_opc_o),
      .r_id_o         (r_id_o),
      .eoc_o          (eoc_o),
      .fetch_enable_o (fetch_enable_o),
      .return_o       (return_o),
      .irq_o          (irq_o)
   );

   // 40 ns clock
   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // Cycle counter and run limit
   initial begin
      while (!(limit_set && (cycles > cycle_limit))) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ******************************
   // Reporting helpers
   // ******************************
   task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp_val,
                                  input logic [DATA_W-1:0] act_val);
      $display("error %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
      test_errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", test_name, msg);
      test_errors++;
   endtask

   // Unit field 11:8 above 2 is unmapped
   function automatic logic unmapped(input logic [DATA_W-1:0] addr);
      return addr[11:8] > 4'd2;
   endfunction

   task automatic check_response(input logic [ID_W-1:0] id, input logic exp_opc);
      if (r_valid_o !== 1'b1) begin
         report_failure("no response two edges after the request");
      end
      if (r_id_o !== id) begin
         report_mismatch("r_id_o", DATA_W'(id), DATA_W'(r_id_o));
      end
      if (r_opc_o !== exp_opc) begin
         report_mismatch("r_opc_o", DATA_W'(exp_opc), DATA_W'(r_opc_o));
      end
   endtask

   // ******************************
   // Bus transactions
   // ******************************
   // One request, response two edges later, then idle again
   task automatic bus_access(input logic is_read, input logic [DATA_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
      logic [ID_W-1:0] id;
      id      = ID_W'($urandom);
      req_i   = 1'b1;
      add_i   = addr[ADDR_W-1:0];
      wen_i   = is_read;
      wdata_i = wdata;
      id_i    = id;
      @(posedge clk_i);
      #2;
      req_i = 1'b0;
      if (r_valid_o !== 1'b0) begin
         report_failure("response came one cycle early");
      end
      @(posedge clk_i);
      #2;
      check_response(id, unmapped(addr));
      rdata = r_rdata_o;
      @(posedge clk_i);
      #2;
      if (r_valid_o !== 1'b0) begin
         report_failure("r_valid_o stayed high for more than one cycle");
      end
   endtask

   // Two reads on consecutive cycles, answered in order
   task automatic bus_read_pair(input logic [DATA_W-1:0] addr,
                                output logic [DATA_W-1:0] rdata_a,
                                output logic [DATA_W-1:0] rdata_b);
      logic [ID_W-1:0] id_a;
      logic [ID_W-1:0] id_b;
      id_a    = ID_W'($urandom);
      id_b    = id_a + 1'b1;
      req_i   = 1'b1;
      add_i   = addr[ADDR_W-1:0];
      wen_i   = 1'b1;
      id_i    = id_a;
      @(posedge clk_i);
      #2;
      id_i = id_b;
      if (r_valid_o !== 1'b0) begin
         report_failure("first response came one cycle early");
      end
      @(posedge clk_i);
      #2;
      req_i = 1'b0;
      check_response(id_a, unmapped(addr));
      rdata_a = r_rdata_o;
      @(posedge clk_i);
      #2;
      check_response(id_b, unmapped(addr));
      rdata_b = r_rdata_o;
      @(posedge clk_i);
      #2;
      if (r_valid_o !== 1'b0) begin
         report_failure("extra response after the pair");
      end
   endtask

   // One-cycle event pulse, irq settles two edges later
   task automatic pulse_events(input logic [DATA_W-1:0] bits);
      ext_events_i = bits[NB_EXT_EVENTS-1:0];
      @(posedge clk_i);
      #2;
      ext_events_i = '0;
      repeat (2) @(posedge clk_i);
      #2;
   endtask

   task automatic poll_read(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] mask,
                            input logic [DATA_W-1:0] exp_val);
      logic [DATA_W-1:0] rdata;
      int unsigned       start;
      bit                seen;
      start = cycles;
      seen  = 1'b0;
      rdata = '0;
      while (!seen && ((cycles - start) < POLL_CYCLES)) begin
         bus_access(1'b1, addr, '0, rdata);
         seen = ((rdata & mask) == exp_val);
      end
      if (!seen) begin
         report_mismatch("polled r_rdata_o", exp_val, rdata & mask);
      end
   endtask

   task automatic check_level(input string sel, input logic [DATA_W-1:0] level);
      logic [DATA_W-1:0] actual;
      bit                known;
      known = 1'b1;
      case (sel)
         "eoc":   actual = DATA_W'(eoc_o);
         "fetch": actual = DATA_W'(fetch_enable_o);
         "ret":   actual = DATA_W'(return_o);
         "irq":   actual = DATA_W'(irq_o);
         default: begin
            actual = '0;
            known  = 1'b0;
         end
      endcase
      if (!known) begin
         report_failure({"stimulus names an unknown output ", sel});
      end else if (actual !== level) begin
         report_mismatch(sel, level, actual);
      end
   endtask

   // ******************************
   // Stimulus file and test loop
   // ******************************
   task automatic load_stimulus(output bit ok);
      int                fd;
      int                count;
      string             line;
      string             name;
      string             op;
      string             out;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] exp_val;
      logic [DATA_W-1:0] level;
      fd = $fopen(STIM_FILE, "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank and comment lines
            if ((line.len() > 1) && (line.getc(0) != "#")) begin
               count = $sscanf(line, "%s %s %h %h %h %s %h",
                               name, op, addr, data, exp_val, out, level);
               if (count == 7) begin
                  names.push_back(name);
                  ops.push_back(op);
                  addrs.push_back(addr);
                  datas.push_back(data);
                  exp_vals.push_back(exp_val);
                  outs.push_back(out);
                  levels.push_back(level);
               end else begin
                  $display("malformed stimulus line: %s", line);
                  ok = 1'b0;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_test(input int idx);
      logic [DATA_W-1:0] rdata_a;
      logic [DATA_W-1:0] rdata_b;
      test_name   = names[idx];
      test_errors = 0;
      case (ops[idx])
         "R", "W": begin
            bus_access(ops[idx] == "R", addrs[idx], datas[idx], rdata_a);
            if (rdata_a !== exp_vals[idx]) begin
               report_mismatch("r_rdata_o", exp_vals[idx], rdata_a);
            end
         end
         "M": begin
            bus_access(1'b1, addrs[idx], datas[idx], rdata_a);
            if (rdata_a > exp_vals[idx]) begin
               report_mismatch("r_rdata_o upper bound", exp_vals[idx], rdata_a);
            end
         end
         "D": begin
            bus_read_pair(addrs[idx], rdata_a, rdata_b);
            if (rdata_a !== exp_vals[idx]) begin
               report_mismatch("first r_rdata_o", exp_vals[idx], rdata_a);
            end
            if (rdata_b !== exp_vals[idx]) begin
               report_mismatch("second r_rdata_o", exp_vals[idx], rdata_b);
            end
         end
         "E": pulse_events(datas[idx]);
         "P": poll_read(addrs[idx], datas[idx], exp_vals[idx]);
         default: report_failure({"stimulus has an unknown operation ", ops[idx]});
      endcase
      if (outs[idx] != "-") begin
         check_level(outs[idx], levels[idx]);
      end
      tests_run++;
      if (test_errors == 0) begin
         $display("ok      %s", test_name);
      end else begin
         tests_failed++;
         $display("failed  %s", test_name);
      end
   endtask

   initial begin
      bit loaded;
      void'($urandom(18171));
      rst_ni       = 1'b0;
      req_i        = 1'b0;
      add_i        = '0;
      wen_i        = 1'b0;
      wdata_i      = '0;
      id_i         = '0;
      ext_events_i = '0;
      tests_run    = 0;
      tests_failed = 0;
      load_stimulus(loaded);
      if (!loaded || (names.size() == 0)) begin
         $display("could not read the tests from %s", STIM_FILE);
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         cycle_limit = 20 * names.size() + 200;
         limit_set   = 1'b1;
         // Reset for 4 cycles
         repeat (4) @(posedge clk_i);
         #2;
         rst_ni = 1'b1;
         foreach (names[i]) begin
            run_test(i);
         end
         $display("tests run %0d, passed %0d, failed %0d",
                  tests_run, tests_run - tests_failed, tests_failed);
         if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
         end else begin
            $display("SOME TESTS FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* cluster_periph.f */
logic/periph_bus_pkg.sv
logic/cluster_ctrl_pkg.sv
logic/periph_req_if.sv
logic/periph_decode.sv
logic/cluster_ctrl_unit.sv
logic/timer_unit.sv
logic/event_unit.sv
logic/periph_result.sv
logic/cluster_periph_top.sv
bench/cluster_periph_tb.sv

/* Makefile */
# Verilator lint and simulation of the cluster peripheral block

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
SIM_FLAGS ?= $(FLAGS) -Wno-fatal
TOP       ?= cluster_periph_tb
FILELIST  ?= cluster_periph.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code of the model
sim:
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cluster_periph_stimulus.txt */
# name op addr data expect out level   (addr, data, expect and level in hex, out - for none)
# op: W write, R read, D two back-to-back reads, E event pulse, P poll read, M read at most
ctrl_eoc_wr     W 000 00000001 00000000 eoc   1
ctrl_eoc_rd     R 000 00000000 00000001 -     0
ctrl_fetch_wr   W 004 0000000a 00000000 fetch a
ctrl_ret_wr     W 008 00000003 00000000 ret   3
ctrl_ret_rd     R 008 00000000 00000003 -     0
resp_b2b        D 004 00000000 0000000a -     0
unmap_wr_eoc    W 800 00000000 deadbeef eoc   1
unmap_wr_fetch  W 304 0000000f deadbeef fetch a
unmap_rd        R f08 00000000 deadbeef ret   3
unmap_eoc_rd    R 000 00000000 00000001 -     0
unmap_fetch_rd  R 004 00000000 0000000a -     0
unmap_ret_rd    R 008 00000000 00000003 -     0
evt_mask0_wr    W 200 00000001 00000000 -     0
evt_mask2_wr    W 208 00000004 00000000 -     0
evt_mask2_rd    R 208 00000000 00000004 -     0
evt_pulse0      E 000 00000001 00000000 irq   1
evt_pulse2      E 000 00000004 00000000 irq   5
evt_buffer_rd   R 210 00000000 00000005 irq   5
evt_clear_wr    W 214 00000005 00000000 irq   0
evt_buffer_clr  R 210 00000000 00000000 irq   0
tmr_cmp_wr      W 108 00000005 00000000 -     0
tmr_en_wr       W 100 00000001 00000000 -     0
tmr_event       P 210 00000100 00000100 irq   0
tmr_count_rd    M 104 00000000 00000005 -     0
tmr_off_wr      W 100 00000000 00000000 -     0
tmr_clear_wr    W 214 00000100 00000000 -     0
tmr_buffer_rd   R 210 00000000 00000000 irq   0
